// File: hw/udp_link_pkg.sv
package udp_link_pkg;

    // Session controller states
    typedef enum logic [3:0] {
        UNINITED     = 4'd0,
        ARP_REQ      = 4'd1,
        ARP_WAIT_MAC = 4'd2,
        ARP_WAIT     = 4'd3,
        IDLE         = 4'd4,
        GEN_REQ      = 4'd5,
        WRITE_IDX1   = 4'd6,
        WRITE_IDX2   = 4'd7,
        WRITE_DATA   = 4'd8
    } session_state_t;

    // Transmit opcode from the session to the frame builder
    typedef enum logic {
        FRAME_ARP_REQ = 1'b0,
        FRAME_UDP     = 1'b1
    } frame_kind_t;

    // Ethertypes
    localparam logic [15:0] ETH_TYPE_IP  = 16'h0800;
    localparam logic [15:0] ETH_TYPE_ARP = 16'h0806;

    // ARP opcodes
    localparam logic [15:0] ARP_OP_REQUEST = 16'h0001;
    localparam logic [15:0] ARP_OP_REPLY   = 16'h0002;

    localparam logic [7:0] IP_PROTO_UDP = 8'd17;

    // 14 Ethernet + 28 ARP, or 14 Ethernet + 20 IP + 8 UDP
    localparam int HDR_LEN = 42;

endpackage : udp_link_pkg

// File: hw/udp_session.sv
`timescale 1ns/100ps

module udp_session #(
    parameter int ARP_WAIT_CYCLES = 25_000_000
) (
    input  logic                      rgmii_clk,
    input  logic                      arp_rstn,
    input  logic                      trig,
    input  logic [15:0]               index,
    output logic                      tx_read_en,
    input  logic [7:0]                tx_data,
    input  logic [15:0]               tx_data_len,
    output logic                      connected,
    output logic                      frame_req,
    output udp_link_pkg::frame_kind_t frame_kind,
    output logic [15:0]               app_length,
    output logic                      app_valid,
    output logic [7:0]                app_data,
    input  logic                      udp_send_ack,
    input  logic                      mac_send_end,
    input  logic                      arp_found
);

    // Shared counter must hold the ARP wait as well as a 16-bit length
    localparam int WAIT_W = $clog2(ARP_WAIT_CYCLES + 1);
    localparam int CNT_W  = (WAIT_W > 17) ? WAIT_W : 17;

    udp_link_pkg::session_state_t state;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] len_ext;
    logic             wait_done;

    // Two index bytes go ahead of the payload
    assign app_length = tx_data_len + 16'd2;
    assign len_ext    = CNT_W'(tx_data_len);
    assign wait_done  = (cnt == CNT_W'(ARP_WAIT_CYCLES - 1));

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            state      <= udp_link_pkg::UNINITED;
            cnt        <= '0;
            frame_req  <= 1'b0;
            frame_kind <= udp_link_pkg::FRAME_ARP_REQ;
            connected  <= 1'b0;
            tx_read_en <= 1'b0;
            app_valid  <= 1'b0;
        end else begin
            frame_req <= 1'b0;
            case (state)
                udp_link_pkg::UNINITED: begin
                    if (wait_done) begin
                        cnt   <= '0;
                        state <= udp_link_pkg::ARP_REQ;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                udp_link_pkg::ARP_REQ: begin
                    frame_req  <= 1'b1;
                    frame_kind <= udp_link_pkg::FRAME_ARP_REQ;
                    state      <= udp_link_pkg::ARP_WAIT_MAC;
                end
                udp_link_pkg::ARP_WAIT_MAC: begin
                    if (mac_send_end) begin
                        cnt   <= '0;
                        state <= udp_link_pkg::ARP_WAIT;
                    end
                end
                udp_link_pkg::ARP_WAIT: begin
                    if (arp_found) begin
                        connected <= 1'b1;
                        state     <= udp_link_pkg::IDLE;
                    end else if (wait_done) begin
                        // No answer, settle again and retry
                        cnt   <= '0;
                        state <= udp_link_pkg::UNINITED;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                udp_link_pkg::IDLE: begin
                    app_valid  <= 1'b0;
                    tx_read_en <= 1'b0;
                    if (trig) begin
                        frame_req  <= 1'b1;
                        frame_kind <= udp_link_pkg::FRAME_UDP;
                        state      <= udp_link_pkg::GEN_REQ;
                    end
                end
                udp_link_pkg::GEN_REQ: begin
                    if (udp_send_ack) begin
                        state <= udp_link_pkg::WRITE_IDX1;
                    end
                end
                udp_link_pkg::WRITE_IDX1: begin
                    // FIFO read starts early to cover its one cycle latency
                    app_valid  <= 1'b1;
                    tx_read_en <= (tx_data_len != 16'd0);
                    cnt        <= '0;
                    state      <= udp_link_pkg::WRITE_IDX2;
                end
                udp_link_pkg::WRITE_IDX2: begin
                    tx_read_en <= (tx_data_len > 16'd1);
                    if (tx_data_len != 16'd0) begin
                        state <= udp_link_pkg::WRITE_DATA;
                    end else begin
                        state <= udp_link_pkg::IDLE;
                    end
                end
                udp_link_pkg::WRITE_DATA: begin
                    // cnt bytes written, cnt+2 reads issued so far
                    cnt        <= cnt + 1'b1;
                    tx_read_en <= (cnt + 2 < len_ext);
                    if (cnt == len_ext - 1'b1) begin
                        state <= udp_link_pkg::IDLE;
                    end
                end
                default: begin
                    state <= udp_link_pkg::UNINITED;
                end
            endcase
        end
    end

    always_ff @(posedge rgmii_clk) begin
        case (state)
            udp_link_pkg::WRITE_IDX1: app_data <= index[15:8];
            udp_link_pkg::WRITE_IDX2: app_data <= index[7:0];
            udp_link_pkg::WRITE_DATA: app_data <= tx_data;
            default:                  app_data <= app_data;
        endcase
    end

endmodule : udp_session

// File: hw/eth_frame_tx.sv
`timescale 1ns/100ps

module eth_frame_tx #(
    parameter logic [47:0] LOCAL_MAC  = 48'h11_11_11_11_11_11,
    parameter logic [31:0] LOCAL_IP   = 32'hC0_A8_01_6E,
    parameter logic [15:0] LOCAL_PORT = 16'h8080,
    parameter logic [31:0] DEST_IP    = 32'hC0_A8_01_69,
    parameter logic [15:0] DEST_PORT  = 16'h8080
) (
    input  logic                      rgmii_clk,
    input  logic                      arp_rstn,
    input  logic                      frame_req,
    input  udp_link_pkg::frame_kind_t frame_kind,
    input  logic [15:0]               app_length,
    input  logic                      app_valid,
    input  logic [7:0]                app_data,
    input  logic [47:0]               peer_mac,
    output logic                      udp_send_ack,
    output logic                      mac_send_end,
    output logic                      mac_tx_valid,
    output logic [7:0]                mac_tx_data
);

    localparam int HL       = udp_link_pkg::HDR_LEN;
    localparam int HDR_BITS = HL * 8;

    logic                      busy;
    logic [16:0]               cnt;
    udp_link_pkg::frame_kind_t kind_q;
    logic [15:0]               len_q;
    logic [16:0]               last_idx;
    logic                      in_hdr;
    logic [HDR_BITS-1:0]       arp_hdr;
    logic [HDR_BITS-1:0]       udp_hdr;
    logic [HDR_BITS-1:0]       hdr_sel;
    logic [5:0]                hdr_pos;
    logic [7:0]                hdr_byte;

    // Broadcast request asking for DEST_IP
    assign arp_hdr = {
        48'hFFFF_FFFF_FFFF, LOCAL_MAC, udp_link_pkg::ETH_TYPE_ARP,
        16'h0001, udp_link_pkg::ETH_TYPE_IP, 8'd6, 8'd4,
        udp_link_pkg::ARP_OP_REQUEST,
        LOCAL_MAC, LOCAL_IP,
        48'h0, DEST_IP
    };

    // Checksums left at zero
    assign udp_hdr = {
        peer_mac, LOCAL_MAC, udp_link_pkg::ETH_TYPE_IP,
        8'h45, 8'h00, 16'd28 + len_q,
        16'h0000, 16'h4000,
        8'd64, udp_link_pkg::IP_PROTO_UDP, 16'h0000,
        LOCAL_IP, DEST_IP,
        LOCAL_PORT, DEST_PORT, 16'd8 + len_q, 16'h0000
    };

    assign hdr_sel = (kind_q == udp_link_pkg::FRAME_UDP) ? udp_hdr : arp_hdr;

    // Header byte n sits at bits (HL-1-n)*8
    assign hdr_pos  = 6'(HL - 1) - cnt[5:0];
    assign hdr_byte = hdr_sel[{hdr_pos, 3'b000} +: 8];

    assign in_hdr = (cnt < 17'(HL));

    always_comb begin
        if (kind_q == udp_link_pkg::FRAME_UDP) begin
            last_idx = 17'(HL - 1) + 17'(len_q);
        end else begin
            last_idx = 17'(HL - 1);
        end
    end

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            busy         <= 1'b0;
            cnt          <= '0;
            udp_send_ack <= 1'b0;
            mac_send_end <= 1'b0;
            mac_tx_valid <= 1'b0;
        end else begin
            udp_send_ack <= 1'b0;
            mac_send_end <= 1'b0;
            mac_tx_valid <= 1'b0;
            if (!busy) begin
                if (frame_req) begin
                    busy <= 1'b1;
                    cnt  <= '0;
                end
            end else if (in_hdr || app_valid) begin
                mac_tx_valid <= 1'b1;
                cnt          <= cnt + 1'b1;
                if (cnt == last_idx) begin
                    mac_send_end <= 1'b1;
                    busy         <= 1'b0;
                end
                // Ack lands with byte 39 so the session's first byte follows byte 41
                if (kind_q == udp_link_pkg::FRAME_UDP && cnt == 17'(HL - 3)) begin
                    udp_send_ack <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge rgmii_clk) begin
        if (!busy && frame_req) begin
            kind_q <= frame_kind;
            len_q  <= app_length;
        end
        if (busy) begin
            mac_tx_data <= in_hdr ? hdr_byte : app_data;
        end
    end

endmodule : eth_frame_tx

// File: hw/eth_frame_rx.sv
`timescale 1ns/100ps

module eth_frame_rx #(
    parameter logic [47:0] LOCAL_MAC  = 48'h11_11_11_11_11_11,
    parameter logic [31:0] LOCAL_IP   = 32'hC0_A8_01_6E,
    parameter logic [15:0] LOCAL_PORT = 16'h8080,
    parameter logic [31:0] DEST_IP    = 32'hC0_A8_01_69
) (
    input  logic        rgmii_clk,
    input  logic        arp_rstn,
    input  logic        mac_rx_valid,
    input  logic [7:0]  mac_rx_data,
    output logic        arp_found,
    output logic [47:0] peer_mac,
    output logic        rx_valid,
    output logic [7:0]  rx_data,
    output logic [15:0] rx_data_len
);

    localparam int HL       = udp_link_pkg::HDR_LEN;
    localparam int HDR_BITS = HL * 8;

    // Saturates at HL+1 once the header is in
    logic [5:0]          cnt;
    logic [HDR_BITS-1:0] hdr_sr;
    logic                hdr_done;
    logic                frame_end;

    logic [47:0] f_dst_mac;
    logic [15:0] f_eth_type;
    logic [15:0] f_arp_op;
    logic [47:0] f_arp_sha;
    logic [31:0] f_arp_spa;
    logic [31:0] f_arp_tpa;
    logic [7:0]  f_ip_proto;
    logic [31:0] f_ip_dst;
    logic [15:0] f_udp_dport;
    logic [15:0] f_udp_len;

    logic        arp_match;
    logic        udp_match;
    logic [15:0] first_len;
    logic [15:0] pay_left;
    logic [15:0] pay_avail;
    logic        pay_take;

    // Last header byte received ends up in the low bits
    assign f_dst_mac   = hdr_sr[(HL - 6) * 8 +: 48];
    assign f_eth_type  = hdr_sr[(HL - 14) * 8 +: 16];
    assign f_arp_op    = hdr_sr[(HL - 22) * 8 +: 16];
    assign f_arp_sha   = hdr_sr[(HL - 28) * 8 +: 48];
    assign f_arp_spa   = hdr_sr[(HL - 32) * 8 +: 32];
    assign f_arp_tpa   = hdr_sr[(HL - 42) * 8 +: 32];
    assign f_ip_proto  = hdr_sr[(HL - 24) * 8 +: 8];
    assign f_ip_dst    = hdr_sr[(HL - 34) * 8 +: 32];
    assign f_udp_dport = hdr_sr[(HL - 38) * 8 +: 16];
    assign f_udp_len   = hdr_sr[(HL - 40) * 8 +: 16];

    assign hdr_done  = (cnt >= 6'(HL));
    assign frame_end = !mac_rx_valid && (cnt != 6'd0);

    // Reply from the peer to our request
    assign arp_match = (f_eth_type == udp_link_pkg::ETH_TYPE_ARP) &&
                       (f_arp_op == udp_link_pkg::ARP_OP_REPLY) &&
                       (f_arp_spa == DEST_IP) &&
                       (f_arp_tpa == LOCAL_IP);

    assign udp_match = (f_dst_mac == LOCAL_MAC) &&
                       (f_eth_type == udp_link_pkg::ETH_TYPE_IP) &&
                       (f_ip_proto == udp_link_pkg::IP_PROTO_UDP) &&
                       (f_ip_dst == LOCAL_IP) &&
                       (f_udp_dport == LOCAL_PORT) &&
                       (f_udp_len > 16'd8);

    assign first_len = udp_match ? f_udp_len - 16'd8 : 16'd0;
    assign pay_avail = (cnt == 6'(HL)) ? first_len : pay_left;
    assign pay_take  = mac_rx_valid && hdr_done && (pay_avail != 16'd0);

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            cnt       <= '0;
            pay_left  <= '0;
            arp_found <= 1'b0;
            rx_valid  <= 1'b0;
        end else begin
            arp_found <= 1'b0;
            if (mac_rx_valid) begin
                if (cnt <= 6'(HL)) begin
                    cnt <= cnt + 1'b1;
                end
            end else begin
                cnt <= '0;
            end
            if (frame_end && hdr_done && arp_match) begin
                arp_found <= 1'b1;
            end
            rx_valid <= pay_take;
            if (!mac_rx_valid) begin
                pay_left <= '0;
            end else if (pay_take) begin
                pay_left <= pay_avail - 1'b1;
            end
        end
    end

    always_ff @(posedge rgmii_clk) begin
        if (mac_rx_valid && !hdr_done) begin
            hdr_sr <= {hdr_sr[HDR_BITS-9:0], mac_rx_data};
        end
        if (frame_end && hdr_done && arp_match) begin
            peer_mac <= f_arp_sha;
        end
        if (pay_take) begin
            rx_data <= mac_rx_data;
        end
        // Length is set together with the first payload byte
        if (mac_rx_valid && cnt == 6'(HL) && udp_match) begin
            rx_data_len <= first_len;
        end
    end

endmodule : eth_frame_rx

// File: hw/udp_link_top.sv
`timescale 1ns/100ps

module udp_link_top #(
    parameter logic [47:0] LOCAL_MAC       = 48'h11_11_11_11_11_11,
    parameter logic [31:0] LOCAL_IP        = 32'hC0_A8_01_6E,
    parameter logic [15:0] LOCAL_PORT      = 16'h8080,
    parameter logic [31:0] DEST_IP         = 32'hC0_A8_01_69,
    parameter logic [15:0] DEST_PORT       = 16'h8080,
    // 200 ms at 125 MHz
    parameter int          ARP_WAIT_CYCLES = 25_000_000
) (
    input  logic        rgmii_clk,
    input  logic        arp_rstn,
    input  logic        trig,
    input  logic [15:0] index,
    output logic        tx_read_en,
    input  logic [7:0]  tx_data,
    input  logic [15:0] tx_data_len,
    output logic        connected,
    output logic        rx_valid,
    output logic [7:0]  rx_data,
    output logic [15:0] rx_data_len,
    output logic        mac_tx_valid,
    output logic [7:0]  mac_tx_data,
    input  logic        mac_rx_valid,
    input  logic [7:0]  mac_rx_data
);

    logic                      frame_req;
    udp_link_pkg::frame_kind_t frame_kind;
    logic [15:0]               app_length;
    logic                      app_valid;
    logic [7:0]                app_data;
    logic                      udp_send_ack;
    logic                      mac_send_end;
    logic                      arp_found;
    logic [47:0]               peer_mac;

    udp_session #(
        .ARP_WAIT_CYCLES(ARP_WAIT_CYCLES)
    ) u_session (
        .rgmii_clk   (rgmii_clk),
        .arp_rstn    (arp_rstn),
        .trig        (trig),
        .index       (index),
        .tx_read_en  (tx_read_en),
        .tx_data     (tx_data),
        .tx_data_len (tx_data_len),
        .connected   (connected),
        .frame_req   (frame_req),
        .frame_kind  (frame_kind),
        .app_length  (app_length),
        .app_valid   (app_valid),
        .app_data    (app_data),
        .udp_send_ack(udp_send_ack),
        .mac_send_end(mac_send_end),
        .arp_found   (arp_found)
    );

    eth_frame_tx #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .LOCAL_PORT(LOCAL_PORT),
        .DEST_IP   (DEST_IP),
        .DEST_PORT (DEST_PORT)
    ) u_frame_tx (
        .rgmii_clk   (rgmii_clk),
        .arp_rstn    (arp_rstn),
        .frame_req   (frame_req),
        .frame_kind  (frame_kind),
        .app_length  (app_length),
        .app_valid   (app_valid),
        .app_data    (app_data),
        .peer_mac    (peer_mac),
        .udp_send_ack(udp_send_ack),
        .mac_send_end(mac_send_end),
        .mac_tx_valid(mac_tx_valid),
        .mac_tx_data (mac_tx_data)
    );

    eth_frame_rx #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .LOCAL_PORT(LOCAL_PORT),
        .DEST_IP   (DEST_IP)
    ) u_frame_rx (
        .rgmii_clk   (rgmii_clk),
        .arp_rstn    (arp_rstn),
        .mac_rx_valid(mac_rx_valid),
        .mac_rx_data (mac_rx_data),
        .arp_found   (arp_found),
        .peer_mac    (peer_mac),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_data_len (rx_data_len)
    );

endmodule : udp_link_top

// File: tests/tb_udp_link.sv
`timescale 1ns/100ps

module tb_udp_link;

    localparam int FRAME_TIMEOUT = 400;

    logic        rgmii_clk;
    logic        arp_rstn;
    logic        trig;
    logic [15:0] index;
    logic        tx_read_en;
    logic [7:0]  tx_data;
    logic [15:0] tx_data_len;
    logic        connected;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic [15:0] rx_data_len;
    logic        mac_tx_valid;
    logic [7:0]  mac_tx_data;
    logic        mac_rx_valid;
    logic [7:0]  mac_rx_data;

    // Captured DUT output streams
    logic [31:0] tx_bytes[$];
    int          frame_lens[$];
    int          tx_cnt;
    logic [31:0] rx_bytes[$];
    logic [31:0] rx_lens[$];

    // External FIFO model
    logic [7:0]  fifo_q[$];
    logic        rd_seen;

    udp_link_top #(
        .ARP_WAIT_CYCLES(50)
    ) UUT (
        .rgmii_clk   (rgmii_clk),
        .arp_rstn    (arp_rstn),
        .trig        (trig),
        .index       (index),
        .tx_read_en  (tx_read_en),
        .tx_data     (tx_data),
        .tx_data_len (tx_data_len),
        .connected   (connected),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_data_len (rx_data_len),
        .mac_tx_valid(mac_tx_valid),
        .mac_tx_data (mac_tx_data),
        .mac_rx_valid(mac_rx_valid),
        .mac_rx_data (mac_rx_data)
    );

    always #2 rgmii_clk = ~rgmii_clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Byte i of an n-byte value, first byte in the top position
    function automatic logic [31:0] byte_at(input logic [255:0] val, input int n, input int i);
        logic [255:0] shifted;
        shifted = val >> (8 * (n - 1 - i));
        return {24'h0, shifted[7:0]};
    endfunction

    always @(negedge rgmii_clk) begin
        rd_seen = tx_read_en;
        if (mac_tx_valid) begin
            tx_bytes.push_back({24'h0, mac_tx_data});
            tx_cnt = tx_cnt + 1;
        end else if (tx_cnt != 0) begin
            frame_lens.push_back(tx_cnt);
            tx_cnt = 0;
        end
        if (rx_valid) begin
            rx_bytes.push_back({24'h0, rx_data});
            rx_lens.push_back({16'h0, rx_data_len});
        end
    end

    // Read data follows tx_read_en by one cycle
    always @(posedge rgmii_clk) begin
        #1;
        if (rd_seen) begin
            if (fifo_q.size() == 0) begin
                abort_run("FIFO read while the FIFO was empty");
            end else begin
                tx_data = fifo_q.pop_front();
            end
        end
    end

    task automatic feed_rx(input int n, input logic [255:0] val);
        logic [31:0] b;
        for (int i = 0; i < n; i++) begin
            b = byte_at(val, n, i);
            @(posedge rgmii_clk);
            #1;
            mac_rx_valid = 1'b1;
            mac_rx_data  = b[7:0];
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge rgmii_clk);
            #1;
            mac_rx_valid = 1'b0;
        end
    endtask

    task automatic push_fifo(input int n, input logic [255:0] val);
        logic [31:0] b;
        for (int i = 0; i < n; i++) begin
            b = byte_at(val, n, i);
            fifo_q.push_back(b[7:0]);
        end
    endtask

    task automatic pulse_trig(input int len, input logic [255:0] val);
        @(posedge rgmii_clk);
        #1;
        trig        = 1'b1;
        index       = val[15:0];
        tx_data_len = 16'(len);
        @(posedge rgmii_clk);
        #1;
        trig = 1'b0;
    endtask

    task automatic wait_frame(input int exp_len);
        int waited;
        waited = 0;
        while (frame_lens.size() == 0 && waited < FRAME_TIMEOUT) begin
            @(posedge rgmii_clk);
            #1;
            waited++;
        end
        if (frame_lens.size() == 0) begin
            $display("Session state at timeout: %s", UUT.u_session.state.name());
            abort_run("Timed out waiting for a transmitted frame");
        end else begin
            check_value(frame_lens.pop_front(), exp_len, "transmitted frame length");
        end
    endtask

    task automatic expect_tx(input int n, input logic [255:0] val);
        for (int i = 0; i < n; i++) begin
            if (tx_bytes.size() == 0) begin
                abort_run("Transmitted frame ended before all expected bytes were seen");
            end else begin
                check_value(tx_bytes.pop_front(), byte_at(val, n, i),
                            $sformatf("transmitted byte %0d of line", i));
            end
        end
    endtask

    // Whole payload of one datagram, rx_data_len must match its size
    task automatic expect_rx(input int n, input logic [255:0] val);
        for (int i = 0; i < n; i++) begin
            if (rx_bytes.size() == 0) begin
                abort_run("Received payload is shorter than expected");
            end else begin
                check_value(rx_bytes.pop_front(), byte_at(val, n, i),
                            $sformatf("received payload byte %0d", i));
                check_value(rx_lens.pop_front(), n, "rx_data_len");
            end
        end
    endtask

    task automatic run_command(input logic [7:0] cmd, input int n, input logic [255:0] val);
        case (cmd)
            "R": feed_rx(n, val);
            "G": idle_cycles(n);
            "P": push_fifo(n, val);
            "T": pulse_trig(n, val);
            "E": expect_tx(n, val);
            "U": expect_rx(n, val);
            "W": wait_frame(n);
            "C": check_value(32'(connected), n, "connected level");
            default: abort_run("Unknown command in the stimulus file");
        endcase
    endtask

    initial begin
        int           fd;
        int           code;
        logic [7:0]   cmd;
        int           n;
        logic [255:0] val;
        logic [1023:0] line;
        logic         done;

        rgmii_clk    = 1'b0;
        arp_rstn     = 1'b0;
        trig         = 1'b0;
        index        = '0;
        tx_data      = '0;
        tx_data_len  = '0;
        mac_rx_valid = 1'b0;
        mac_rx_data  = '0;
        rd_seen      = 1'b0;
        tx_cnt       = 0;

        repeat (16) @(posedge rgmii_clk);
        #1;
        arp_rstn = 1'b1;
        @(posedge rgmii_clk);
        #1;
        check_value(32'(connected), 0, "connected after reset");
        check_value(32'(mac_tx_valid), 0, "mac_tx_valid after reset");
        check_value(32'(tx_read_en), 0, "tx_read_en after reset");
        check_value(32'(rx_valid), 0, "rx_valid after reset");

        fd = $fopen("tests/udp_link_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file tests/udp_link_tests.txt");
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", cmd);
                if (code != 1) begin
                    done = 1'b1;
                end else if (cmd == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    code = $fscanf(fd, "%h %h", n, val);
                    if (code != 2) begin
                        done = 1'b1;
                        abort_run("Malformed line in the stimulus file");
                    end else begin
                        run_command(cmd, n, val);
                    end
                end
            end
            $fclose(fd);

            idle_cycles(4);
            check_value(tx_bytes.size(), 0, "unchecked transmitted bytes");
            check_value(frame_lens.size(), 0, "unexpected transmitted frames");
            check_value(rx_bytes.size(), 0, "unexpected received payload bytes");
            check_value(fifo_q.size(), 0, "FIFO bytes left unread");
            $display("Verification passed");
            $finish;
        end
    end

endmodule : tb_udp_link

// File: udp_link.f
hw/udp_link_pkg.sv
hw/udp_session.sv
hw/eth_frame_tx.sv
hw/eth_frame_rx.sv
hw/udp_link_top.sv
tests/tb_udp_link.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_udp_link
FILELIST  ?= udp_link.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/udp_link_tests.txt
# cmd count value: R rx bytes, P FIFO bytes, E expected tx bytes, U expected rx payload
# G idle cycles, T length index, W expected tx frame length, C expected connected level
W 2a 0
E 0e ffffffffffff1111111111110806
E 1c 0001080006040001111111111111c0a8016e000000000000c0a80169
R 0e 111111111111a0b1c2d3e4f50806
R 1c 0001080006040002a0b1c2d3e4f5c0a80163111111111111c0a8016e
G 04 0
C 00 0
W 2a 0
E 0e ffffffffffff1111111111110806
E 1c 0001080006040001111111111111c0a8016e000000000000c0a80169
R 0e 111111111111a0b1c2d3e4f50806
R 1c 0001080006040002a0b1c2d3e4f5c0a80169111111111111c0a8016e
G 04 0
C 01 0
P 05 a1b2c3d4e5
T 05 1234
G 0a 0
T 05 1234
W 31 0
E 0e a0b1c2d3e4f51111111111110800
E 1c 450000230000400040110000c0a8016ec0a8016980808080000f0000
E 07 1234a1b2c3d4e5
T 00 5678
W 2c 0
E 0e a0b1c2d3e4f51111111111110800
E 1c 4500001e0000400040110000c0a8016ec0a8016980808080000a0000
E 02 5678
R 0e 111111111111a0b1c2d3e4f50800
R 1c 450000200000400040110000c0a80169c0a8016e80808080000c0000
R 04 deadbeef
G 04 0
U 04 deadbeef
R 0e 111111111111a0b1c2d3e4f50800
R 1c 450000200000400040110000c0a80169c0a8016e80808081000c0000
R 04 cafef00d
G 04 0
R 0e 111111111111a0b1c2d3e4f50800
R 1c 450000200000400040110000c0a80169c0a8016f80808080000c0000
R 04 0badf00d
G 04 0
